// File: sim.f
+incdir+.
div_pkg.sv
recip_seed_lut.sv
recip_unit.sv
operand_path.sv
quotient_normalize.sv
mant_div_core.sv
mant_div_properties.sv
tb_mant_div.sv

// File: Bender.yml
package:
  name: mant_div

sources:
  - include_dirs:
      - .
    files:
      - div_pkg.sv
      - recip_seed_lut.sv
      - recip_unit.sv
      - operand_path.sv
      - quotient_normalize.sv
      - mant_div_core.sv
      - target: test
        files:
          - mant_div_properties.sv
          - tb_mant_div.sv

// File: tb_mant_div.sv
`default_nettype none

`include "div_settings.svh"

module tb_mant_div;

  localparam int PERIOD   = 40;
  localparam int LATENCY  = 2;
  localparam int N_ITEMS  = 16 + 200 + 32 + 20 + 100 + 3;
  localparam int WATCHDOG = (N_ITEMS + 50) * PERIOD * 4;
  localparam div_pkg::mant_t ONE = div_pkg::mant_t'(1) << (`MANT_SIZE - 1);

  typedef struct {
    div_pkg::mant_t mant;
    div_pkg::te_t   te;
    bit             exact;
    int             cycle;
  } expect_t;

  logic             clk_i = 1'b0;
  logic             rst;
  logic             in_valid_i;
  logic             in_ready_o;
  div_pkg::div_op_e op_i;
  div_pkg::te_t     te1_i;
  div_pkg::te_t     te2_i;
  div_pkg::mant_t   mant1_i;
  div_pkg::mant_t   mant2_i;
  logic             out_valid_o;
  logic             out_ready_i;
  div_pkg::mant_t   mant_o;
  div_pkg::te_t     te_o;
  logic             frac_truncated_o;

  expect_t     exp_q[$];
  int          cycle = 0;
  int          errors = 0;
  int          stalls = 0;
  int          below_one = 0;
  bit          lat_check = 1'b1;

  mant_div_core u_dut (.*);

  bind mant_div_core mant_div_properties u_properties (.*);

  always #(PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  function automatic void report_mismatch(string name, int expected, int actual);
    errors++;
    $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
  endfunction

  function automatic void report_failure(string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endfunction

  function automatic div_pkg::mant_t rand_mant();
    return div_pkg::mant_t'($urandom) | ONE;
  endfunction

  // reference is the integer quotient floor with one more bit when below one
  task automatic drive_item(input div_pkg::div_op_e op, input div_pkg::te_t te1,
                            input div_pkg::te_t te2, input div_pkg::mant_t m1,
                            input div_pkg::mant_t m2, input bit exact);
    expect_t     e;
    int unsigned num;
    int unsigned q;
    num = (op == div_pkg::OP_RECIP) ? ONE : m1;
    e.te = (op == div_pkg::OP_RECIP) ? -te2 : te1 - te2;
    q = (num << (`MANT_SIZE - 1)) / m2;
    if (q < ONE) begin
      q = (num << `MANT_SIZE) / m2;
      e.te = e.te - 1'b1;
      below_one++;
    end
    e.mant  = div_pkg::mant_t'(q);
    e.exact = exact;
    in_valid_i = 1'b1;
    op_i       = op;
    te1_i      = te1;
    te2_i      = te2;
    mant1_i    = m1;
    mant2_i    = m2;
    do @(negedge clk_i); while (!in_ready_o);
    e.cycle = cycle;
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b0;
    exp_q.push_back(e);
  endtask

  task automatic drive_random_items(input int count, input bit mixed_ops,
                                    input div_pkg::div_op_e op, input bit unit_divisor);
    div_pkg::mant_t m1;
    div_pkg::mant_t m2;
    div_pkg::te_t   te1;
    div_pkg::te_t   te2;
    repeat (count) begin
      m1  = rand_mant();
      m2  = unit_divisor ? ONE : rand_mant();
      te1 = div_pkg::te_t'($urandom);
      te2 = div_pkg::te_t'($urandom);
      if (mixed_ops) begin
        op = div_pkg::div_op_e'($urandom % 2);
      end
      drive_item(op, te1, te2, m1, m2, unit_divisor);
    end
  endtask

  task automatic check_response();
    expect_t e;
    assert (exp_q.size() != 0) else report_failure("output appeared with no item in flight");
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      assert (mant_o == e.mant || (!e.exact && mant_o == e.mant - 1'b1))
        else report_mismatch("mant_o", e.mant, mant_o);
      assert (te_o == e.te) else report_mismatch("te_o", $signed(e.te), $signed(te_o));
      assert (!e.exact || !frac_truncated_o)
        else report_mismatch("frac_truncated_o", 0, frac_truncated_o);
      // a result one below the floor means the product had discarded bits
      assert (mant_o != e.mant - 1'b1 || frac_truncated_o)
        else report_mismatch("frac_truncated_o", 1, frac_truncated_o);
      assert (!lat_check || cycle - e.cycle == LATENCY)
        else report_failure("response latency differs from two cycles");
    end
  endtask

  // outputs are sampled on the falling edge half a cycle away from every change
  always @(negedge clk_i) begin
    if (!rst && out_valid_o && !out_ready_i) begin
      stalls++;
      assert (!in_ready_o) else report_mismatch("in_ready_o", 0, in_ready_o);
    end
    if (!rst && out_valid_o && out_ready_i) begin
      check_response();
    end
  end

  task automatic check_idle();
    @(negedge clk_i);
    assert (!out_valid_o) else report_mismatch("out_valid_o", 0, out_valid_o);
    assert (in_ready_o) else report_mismatch("in_ready_o", 1, in_ready_o);
    @(posedge clk_i);
    #2;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic test_divisor_one();
    drive_random_items(16, 1'b0, div_pkg::OP_DIV, 1'b1);
    wait_drain();
  endtask

  task automatic test_general_division();
    int below_start;
    below_start = below_one;
    // equal operands give a quotient of exactly one
    drive_item(div_pkg::OP_DIV, 8'd3, 8'd1, 8'hb0, 8'hb0, 1'b0);
    drive_random_items(199, 1'b0, div_pkg::OP_DIV, 1'b0);
    wait_drain();
    assert (below_one > below_start) else report_failure("no quotient below one was tested");
  endtask

  task automatic test_reciprocal();
    drive_item(div_pkg::OP_RECIP, 8'd9, 8'd6, rand_mant(), ONE, 1'b1);
    drive_random_items(31, 1'b0, div_pkg::OP_RECIP, 1'b0);
    wait_drain();
  endtask

  task automatic test_latency();
    drive_random_items(10, 1'b1, div_pkg::OP_DIV, 1'b0);
    repeat (3) @(posedge clk_i);
    #2;
    drive_random_items(10, 1'b1, div_pkg::OP_DIV, 1'b0);
    wait_drain();
  endtask

  task automatic test_back_pressure();
    int stall_start;
    bit sent;
    stall_start = stalls;
    sent = 1'b0;
    lat_check = 1'b0;
    fork
      begin
        drive_random_items(100, 1'b1, div_pkg::OP_DIV, 1'b0);
        sent = 1'b1;
      end
      while (!sent) begin
        @(posedge clk_i);
        #2;
        out_ready_i = 1'($urandom);
      end
    join
    out_ready_i = 1'b1;
    wait_drain();
    lat_check = 1'b1;
    assert (stalls > stall_start) else report_failure("the output was never stalled");
  endtask

  task automatic test_reset();
    out_ready_i = 1'b0;
    // one item waits in the output register and one in stage one
    drive_random_items(2, 1'b0, div_pkg::OP_DIV, 1'b0);
    rst = 1'b1;
    exp_q.delete();
    repeat (4) @(posedge clk_i);
    #2;
    rst = 1'b0;
    check_idle();
    out_ready_i = 1'b1;
    repeat (8) @(posedge clk_i);
    #2;
    drive_random_items(1, 1'b0, div_pkg::OP_DIV, 1'b1);
    wait_drain();
  endtask

  initial begin
    #(WATCHDOG);
    $display("Timeout at %0t: responses still missing or the DUT stopped accepting", $time);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(15445));
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    op_i        = div_pkg::OP_DIV;
    te1_i       = '0;
    te2_i       = '0;
    mant1_i     = ONE;
    mant2_i     = ONE;
    out_ready_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #2;
    rst = 1'b0;
    check_idle();
    test_divisor_one();
    test_general_division();
    test_reciprocal();
    test_latency();
    test_back_pressure();
    test_reset();
    assert (exp_q.size() == 0) else report_failure("responses missing at the end of the run");
    $display("Summary: %0d errors, %0d stall cycles, %0d quotients below one",
             errors, stalls, below_one);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mant_div_properties.sv
`default_nettype none

module mant_div_properties (
  input wire logic           clk_i,
  input wire logic           rst,
  input wire logic           in_ready_o,
  input wire logic           out_valid_o,
  input wire logic           out_ready_i,
  input wire div_pkg::mant_t mant_o,
  input wire div_pkg::te_t   te_o,
  input wire logic           frac_truncated_o
);

  // a stalled response keeps its payload until the sink takes it
  payload_stable: assert property (
    @(posedge clk_i) disable iff (rst)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(mant_o) && $stable(te_o) && $stable(frac_truncated_o))
  ) else $error("output payload changed while out_valid_o was stalled");

  valid_low_after_reset: assert property (
    @(posedge clk_i) rst |=> !out_valid_o
  ) else $error("out_valid_o is high in the cycle after reset");

  ready_follows_output: assert property (
    @(posedge clk_i) disable iff (rst) in_ready_o == (!out_valid_o || out_ready_i)
  ) else $error("in_ready_o does not follow the output stall state");

endmodule

`default_nettype wire

// File: mant_div_core.sv
`default_nettype none

module mant_div_core (
  input  wire logic             clk_i,
  input  wire logic             rst,
  input  wire logic             in_valid_i,
  output logic                  in_ready_o,
  input  wire div_pkg::div_op_e op_i,
  input  wire div_pkg::te_t     te1_i,
  input  wire div_pkg::te_t     te2_i,
  input  wire div_pkg::mant_t   mant1_i,
  input  wire div_pkg::mant_t   mant2_i,
  output logic                  out_valid_o,
  input  wire logic             out_ready_i,
  output div_pkg::mant_t        mant_o,
  output div_pkg::te_t          te_o,
  output logic                  frac_truncated_o
);

  logic            stage_adv;
  logic            s1_valid;
  div_pkg::mant_t  s1_num;
  div_pkg::te_t    s1_te_diff;
  div_pkg::recip_t s1_recip;

  assign in_ready_o = stage_adv;

  // stage one, operands and exponent beside the reciprocal
  operand_path u_operand_path (
    .clk_i      (clk_i),
    .rst        (rst),
    .en_i       (stage_adv),
    .valid_i    (in_valid_i),
    .op_i       (op_i),
    .te1_i      (te1_i),
    .te2_i      (te2_i),
    .mant1_i    (mant1_i),
    .s1_valid_o (s1_valid),
    .num_o      (s1_num),
    .te_diff_o  (s1_te_diff)
  );

  recip_unit u_recip_unit (
    .clk_i   (clk_i),
    .rst     (rst),
    .en_i    (stage_adv),
    .mant2_i (mant2_i),
    .recip_o (s1_recip)
  );

  // stage two, multiply and normalize into the output register
  quotient_normalize u_quotient_normalize (
    .clk_i            (clk_i),
    .rst              (rst),
    .valid_i          (s1_valid),
    .out_ready_i      (out_ready_i),
    .num_i            (s1_num),
    .recip_i          (s1_recip),
    .te_diff_i        (s1_te_diff),
    .stage_adv_o      (stage_adv),
    .out_valid_o      (out_valid_o),
    .mant_o           (mant_o),
    .te_o             (te_o),
    .frac_truncated_o (frac_truncated_o)
  );

endmodule

`default_nettype wire

// File: quotient_normalize.sv
`default_nettype none

`include "div_settings.svh"

module quotient_normalize (
  input  wire logic            clk_i,
  input  wire logic            rst,
  input  wire logic            valid_i,
  input  wire logic            out_ready_i,
  input  wire div_pkg::mant_t  num_i,
  input  wire div_pkg::recip_t recip_i,
  input  wire div_pkg::te_t    te_diff_i,
  output logic                 stage_adv_o,
  output logic                 out_valid_o,
  output div_pkg::mant_t       mant_o,
  output div_pkg::te_t         te_o,
  output logic                 frac_truncated_o
);

  localparam int PROD_W  = `MANT_SIZE + `RECIP_BITS;
  // position of the integer one in the product
  localparam int ONE_BIT = (`MANT_SIZE - 1) + (`RECIP_BITS - 1);
  localparam int SNAP_W  = `MANT_SIZE + 1;
  localparam div_pkg::mant_t MANT_ONE = div_pkg::mant_t'(1) << (`MANT_SIZE - 1);

  logic [PROD_W-1:0] prod;
  logic [PROD_W-1:0] shifted;
  logic              below_one;
  logic              near_one;
  div_pkg::mant_t    mant_next;
  div_pkg::te_t      te_next;
  logic              trunc_next;

  // quotient lies in (0.5, 2), product approaches it from below
  assign prod      = PROD_W'(num_i) * PROD_W'(recip_i);
  assign below_one = ~prod[ONE_BIT];

  // a true quotient below one is at most 1 - 1/(2^MANT_SIZE - 1), so a product
  // this close under one can only come from equal operands
  assign near_one  = below_one & (&prod[ONE_BIT-1 -: SNAP_W]);

  assign shifted = below_one ? prod << 1 : prod;

  always_comb begin
    mant_next  = shifted[ONE_BIT -: `MANT_SIZE];
    trunc_next = |shifted[ONE_BIT-`MANT_SIZE:0];
    te_next    = below_one ? te_diff_i - 1'b1 : te_diff_i;
    if (near_one) begin
      mant_next  = MANT_ONE;
      trunc_next = 1'b0;
      te_next    = te_diff_i;
    end
  end

  // whole pipeline moves only when the output slot is free or being drained
  assign stage_adv_o = ~out_valid_o | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else if (stage_adv_o) begin
      out_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stage_adv_o) begin
      mant_o           <= mant_next;
      te_o             <= te_next;
      frac_truncated_o <= trunc_next;
    end
  end

endmodule

`default_nettype wire

// File: operand_path.sv
`default_nettype none

`include "div_settings.svh"

module operand_path (
  input  wire logic             clk_i,
  input  wire logic             rst,
  input  wire logic             en_i,
  input  wire logic             valid_i,
  input  wire div_pkg::div_op_e op_i,
  input  wire div_pkg::te_t     te1_i,
  input  wire div_pkg::te_t     te2_i,
  input  wire div_pkg::mant_t   mant1_i,
  output logic                  s1_valid_o,
  output div_pkg::mant_t        num_o,
  output div_pkg::te_t          te_diff_o
);

  // 1.0 with only the hidden bit set
  localparam div_pkg::mant_t MANT_ONE = div_pkg::mant_t'(1) << (`MANT_SIZE - 1);

  div_pkg::mant_t num_next;
  div_pkg::te_t   te_diff_next;

  always_comb begin
    num_next     = mant1_i;
    te_diff_next = te1_i - te2_i;
    if (op_i == div_pkg::OP_RECIP) begin
      // numerator forced to one, exponent of 1 is zero
      num_next     = MANT_ONE;
      te_diff_next = '0 - te2_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      s1_valid_o <= 1'b0;
    end else if (en_i) begin
      s1_valid_o <= valid_i;
    end
  end

  // same enable as recip_unit keeps both halves of stage one aligned
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      num_o     <= num_next;
      te_diff_o <= te_diff_next;
    end
  end

endmodule

`default_nettype wire

// File: recip_unit.sv
`default_nettype none

`include "div_settings.svh"

module recip_unit (
  input  wire logic            clk_i,
  input  wire logic            rst,
  input  wire logic            en_i,
  input  wire div_pkg::mant_t  mant2_i,
  output div_pkg::recip_t      recip_o
);

  localparam int FRAC_D  = `MANT_SIZE - 1;
  localparam int FRAC_X0 = `LUT_SIZE_OUT;
  localparam int DX_W    = `MANT_SIZE + FRAC_X0 + 1;
  localparam int X0_W    = FRAC_X0 + 1;
  localparam int X1_W    = X0_W + DX_W;
  // x1 = x0 * e carries FRAC_X0 + (FRAC_D + FRAC_X0) fraction bits
  localparam int X1_FRAC = FRAC_D + 2 * FRAC_X0;

  logic [`LUT_SIZE_IN-1:0]  lut_addr;
  logic [`LUT_SIZE_OUT-1:0] seed;
  logic                     frac_zero;
  logic [X0_W-1:0]          x0;
  logic [DX_W-1:0]          dx;
  logic [DX_W-1:0]          err;
  logic [X1_W-1:0]          x1_full;

  // leading fraction bits of the divisor, hidden one dropped
  assign lut_addr  = mant2_i[`MANT_SIZE-2 -: `LUT_SIZE_IN];
  assign frac_zero = (mant2_i[`MANT_SIZE-2:0] == '0);

  recip_seed_lut u_seed_lut (
    .addr_i (lut_addr),
    .seed_o (seed)
  );

  // 1/1 needs the integer bit, which the table cannot hold
  assign x0 = frac_zero ? X0_W'(1) << FRAC_X0 : {1'b0, seed};

  // newton-raphson step x1 = x0 * (2 - d * x0)
  assign dx      = DX_W'(mant2_i) * DX_W'(x0);
  assign err     = (DX_W'(1) << (FRAC_D + FRAC_X0 + 1)) - dx;
  assign x1_full = X1_W'(x0) * X1_W'(err);

  always_ff @(posedge clk_i) begin
    if (rst) begin
      recip_o <= '0;
    end else if (en_i) begin
      // x1 never exceeds 1/d, so the bits above the integer one are zero
      recip_o <= x1_full[X1_FRAC -: `RECIP_BITS];
    end
  end

endmodule

`default_nettype wire

// File: recip_seed_lut.sv
`default_nettype none

`include "div_settings.svh"

module recip_seed_lut (
  input  wire logic [`LUT_SIZE_IN-1:0]  addr_i,
  output logic      [`LUT_SIZE_OUT-1:0] seed_o
);

  localparam int unsigned ENTRIES = 2 ** `LUT_SIZE_IN;

  typedef logic [ENTRIES-1:0][`LUT_SIZE_OUT-1:0] seed_table_t;

  // address a covers [1 + a/2^IN, 1 + (a+1)/2^IN), so its midpoint is
  // 1 + (2a+1)/2^(IN+1) and the reciprocal is 2^(IN+1) / (2^(IN+1) + 2a + 1)
  function automatic seed_table_t build_table();
    seed_table_t table_v;
    longint unsigned num;
    longint unsigned den;
    for (int a = 0; a < ENTRIES; a++) begin
      num = longint'(1) << (`LUT_SIZE_OUT + `LUT_SIZE_IN + 1);
      den = (longint'(1) << (`LUT_SIZE_IN + 1)) + 2 * a + 1;
      // truncated, so every seed sits a little below the true reciprocal
      table_v[a] = `LUT_SIZE_OUT'(num / den);
    end
    return table_v;
  endfunction

  localparam seed_table_t SEED_TABLE = build_table();

  // seed value is fraction only, lies in (0.5, 1)
  assign seed_o = SEED_TABLE[addr_i];

endmodule

`default_nettype wire

// File: div_pkg.sv
`default_nettype none

`include "div_settings.svh"

package div_pkg;

  // divide computes m1 / m2, reciprocal computes 1 / m2
  typedef enum logic {
    OP_DIV   = 1'b0,
    OP_RECIP = 1'b1
  } div_op_e;

  // fixed point with (MANT_SIZE - 1) fraction bits
  typedef logic [`MANT_SIZE-1:0] mant_t;

  typedef logic [`TE_BITS-1:0] te_t;

  // fixed point with (RECIP_BITS - 1) fraction bits
  typedef logic [`RECIP_BITS-1:0] recip_t;

endpackage

`default_nettype wire

// File: div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// mantissa width, hidden one included at the msb
`define MANT_SIZE 8

// total exponent, two's complement
`define TE_BITS 8

// fraction bits of the divisor that address the seed table
`define LUT_SIZE_IN 6

// fraction bits of one seed entry
`define LUT_SIZE_OUT 10

// refined reciprocal, one integer bit and the rest fraction
`define RECIP_BITS (2 * `MANT_SIZE)

`endif
